/* include/soc_config.svh */
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// Bus widths
`define SOC_AWIDTH          16
`define SOC_DWIDTH          32
`define SOC_SWIDTH          4

// Data memory, 512 words of 32 bits
`define SOC_RAM_DEPTH       512
`define SOC_RAM_AWIDTH      9

// Host request and response queues
`define SOC_FIFO_DEPTH      4

`define SOC_IRQ_SOURCES     16
`define SOC_GPIO_WIDTH      8

// Slave select, address bits 15..12
`define SOC_SEL_RAM         4'h0
`define SOC_SEL_IRQ         4'h8
`define SOC_SEL_GPIO        4'h9

// Register word index, address bits 3..2
`define SOC_IRQ_PEND_LO     2'd0
`define SOC_IRQ_PEND_HI     2'd1
`define SOC_IRQ_MASK_LO     2'd2
`define SOC_IRQ_MASK_HI     2'd3
`define SOC_GPIO_IN         2'd0
`define SOC_GPIO_OUT        2'd1
`define SOC_GPIO_DIR        2'd2

`endif

/* design/soc_pkg.sv */
`include "soc_config.svh"

package soc_pkg;

    typedef logic [`SOC_AWIDTH-1:0]      addr_t;
    typedef logic [`SOC_DWIDTH-1:0]      word_t;
    typedef logic [7:0]                  byte_t;
    typedef logic [`SOC_SWIDTH-1:0]      sel_t;
    typedef logic [`SOC_IRQ_SOURCES-1:0] irq_vec_t;

    // Byte load or store from the host
    typedef struct packed {
        logic  we;
        addr_t addr;
        byte_t data;
    } access_req_t;

    // Result of a load
    typedef struct packed {
        byte_t data;
    } access_rsp_t;

endpackage

/* design/bus_fifo.sv */
`timescale 1ns/1ps

module bus_fifo #(
    parameter type         T     = logic [7:0],
    parameter int unsigned DEPTH = 4
) (
    input  logic wb_clk_i,
    input  logic reset_i,

    input  logic in_valid_i,
    output logic in_ready_o,
    input  T     in_data_i,

    output logic out_valid_o,
    input  logic out_ready_i,
    output T     out_data_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    T                 mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    // Wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign in_ready_o  = (count_q != CNT_W'(DEPTH));
    assign out_valid_o = (count_q != '0);
    assign push        = in_valid_i && in_ready_o;
    assign pop         = out_valid_o && out_ready_i;
    assign out_data_o  = mem_q[rd_ptr_q];

    always_ff @(posedge wb_clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_data_i;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            // Occupancy only moves when exactly one side transfers
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

/* design/data_ram.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module data_ram import soc_pkg::*; (
    input  logic                       wb_clk_i,
    input  logic                       en_i,
    input  sel_t                       we_i,
    input  logic [`SOC_RAM_AWIDTH-1:0] addr_i,
    input  word_t                      wdat_i,
    output word_t                      rdat_o
);

    word_t mem_q [`SOC_RAM_DEPTH];

    // Per-lane writes
    always_ff @(posedge wb_clk_i) begin
        if (en_i) begin
            for (int lane = 0; lane < `SOC_SWIDTH; lane++) begin
                if (we_i[lane]) begin
                    mem_q[addr_i][lane*8 +: 8] <= wdat_i[lane*8 +: 8];
                end
            end
        end
    end

    // Registered read, old data on a write cycle
    always_ff @(posedge wb_clk_i) begin
        if (en_i) begin
            rdat_o <= mem_q[addr_i];
        end
    end

endmodule

/* design/irq_ctrl.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module irq_ctrl import soc_pkg::*; (
    input  logic       wb_clk_i,
    input  logic       reset_i,
    input  logic       stb_i,
    input  logic       we_i,
    input  logic [1:0] reg_i,
    input  byte_t      wdat_i,
    output byte_t      rdat_o,
    input  irq_vec_t   irq_src_i,
    output logic [1:0] irq_o
);

    irq_vec_t pend_q;
    irq_vec_t mask_q;
    irq_vec_t pend_clr;
    irq_vec_t active;

    // Write one to clear pending
    always_comb begin
        pend_clr = '0;
        if (stb_i && we_i) begin
            case (reg_i)
                `SOC_IRQ_PEND_LO: pend_clr[7:0]  = wdat_i;
                `SOC_IRQ_PEND_HI: pend_clr[15:8] = wdat_i;
                default:          pend_clr       = '0;
            endcase
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            pend_q <= '0;
            mask_q <= '0;
        end else begin
            // A source still high wins over the clear
            pend_q <= (pend_q & ~pend_clr) | irq_src_i;
            if (stb_i && we_i) begin
                case (reg_i)
                    `SOC_IRQ_MASK_LO: mask_q[7:0]  <= wdat_i;
                    `SOC_IRQ_MASK_HI: mask_q[15:8] <= wdat_i;
                    default:          mask_q       <= mask_q;
                endcase
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (stb_i && !we_i) begin
            case (reg_i)
                `SOC_IRQ_PEND_LO: rdat_o <= pend_q[7:0];
                `SOC_IRQ_PEND_HI: rdat_o <= pend_q[15:8];
                `SOC_IRQ_MASK_LO: rdat_o <= mask_q[7:0];
                default:          rdat_o <= mask_q[15:8];
            endcase
        end
    end

    // One line per group of eight
    assign active = pend_q & mask_q;
    assign irq_o  = {|active[15:8], |active[7:0]};

endmodule

/* design/gpio_regs.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module gpio_regs import soc_pkg::*; (
    input  logic                       wb_clk_i,
    input  logic                       reset_i,
    input  logic                       stb_i,
    input  logic                       we_i,
    input  logic [1:0]                 reg_i,
    input  byte_t                      wdat_i,
    output byte_t                      rdat_o,
    input  logic [`SOC_GPIO_WIDTH-1:0] gpio_i,
    output logic [`SOC_GPIO_WIDTH-1:0] gpio_o,
    output logic [`SOC_GPIO_WIDTH-1:0] gpio_oe_o
);

    logic [`SOC_GPIO_WIDTH-1:0] out_q;
    logic [`SOC_GPIO_WIDTH-1:0] dir_q;
    logic [`SOC_GPIO_WIDTH-1:0] in_meta_q;
    logic [`SOC_GPIO_WIDTH-1:0] in_sync_q;

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            out_q <= '0;
            dir_q <= '0;
        end else if (stb_i && we_i) begin
            case (reg_i)
                `SOC_GPIO_OUT: out_q <= wdat_i;
                `SOC_GPIO_DIR: dir_q <= wdat_i;
                default:       out_q <= out_q;
            endcase
        end
    end

    // Two-stage synchronizer for the pins
    always_ff @(posedge wb_clk_i) begin
        in_meta_q <= gpio_i;
        in_sync_q <= in_meta_q;
    end

    always_ff @(posedge wb_clk_i) begin
        if (stb_i && !we_i) begin
            case (reg_i)
                `SOC_GPIO_IN:  rdat_o <= in_sync_q;
                `SOC_GPIO_OUT: rdat_o <= out_q;
                `SOC_GPIO_DIR: rdat_o <= dir_q;
                default:       rdat_o <= '0;
            endcase
        end
    end

    assign gpio_o    = out_q;
    assign gpio_oe_o = dir_q;

endmodule

/* design/periph_bus.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module periph_bus import soc_pkg::*; (
    input  logic                       wb_clk_i,
    input  logic                       reset_i,

    input  logic                       bus_stb_i,
    input  logic                       bus_we_i,
    input  addr_t                      bus_adr_i,
    input  sel_t                       bus_sel_i,
    input  word_t                      bus_wdat_i,
    output logic                       bus_ack_o,
    output word_t                      bus_rdat_o,

    input  irq_vec_t                   irq_src_i,
    output logic [1:0]                 irq_o,

    input  logic [`SOC_GPIO_WIDTH-1:0] gpio_i,
    output logic [`SOC_GPIO_WIDTH-1:0] gpio_o,
    output logic [`SOC_GPIO_WIDTH-1:0] gpio_oe_o
);

    logic [3:0] slave_sel;
    logic [3:0] hit_q;
    logic       ack_q;
    logic       ram_stb;
    logic       irq_stb;
    logic       gpio_stb;
    logic       byte_we;
    sel_t       ram_we;
    word_t      ram_rdat;
    byte_t      irq_rdat;
    byte_t      gpio_rdat;

    // ------------------------------
    // Decode
    // ------------------------------
    assign slave_sel = bus_adr_i[15:12];
    assign ram_stb   = bus_stb_i && (slave_sel == `SOC_SEL_RAM);
    assign irq_stb   = bus_stb_i && (slave_sel == `SOC_SEL_IRQ);
    assign gpio_stb  = bus_stb_i && (slave_sel == `SOC_SEL_GPIO);

    assign ram_we  = {`SOC_SWIDTH{bus_we_i}} & bus_sel_i;
    // Byte registers live on lane 0 only
    assign byte_we = bus_we_i && bus_sel_i[0];

    // One acknowledge for every target, mapped or not
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= bus_stb_i;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (bus_stb_i) begin
            hit_q <= slave_sel;
        end
    end

    assign bus_ack_o = ack_q;

    always_comb begin
        case (hit_q)
            `SOC_SEL_RAM:  bus_rdat_o = ram_rdat;
            `SOC_SEL_IRQ:  bus_rdat_o = {24'h0, irq_rdat};
            `SOC_SEL_GPIO: bus_rdat_o = {24'h0, gpio_rdat};
            default:       bus_rdat_o = '0;
        endcase
    end

    // ------------------------------
    // Slaves
    // ------------------------------
    data_ram u_data_ram (
        .wb_clk_i ( wb_clk_i                          ),
        .en_i     ( ram_stb                           ),
        .we_i     ( ram_we                            ),
        .addr_i   ( bus_adr_i[`SOC_RAM_AWIDTH+1:2]    ),
        .wdat_i   ( bus_wdat_i                        ),
        .rdat_o   ( ram_rdat                          )
    );

    irq_ctrl u_irq_ctrl (
        .wb_clk_i  ( wb_clk_i         ),
        .reset_i   ( reset_i          ),
        .stb_i     ( irq_stb          ),
        .we_i      ( byte_we          ),
        .reg_i     ( bus_adr_i[3:2]   ),
        .wdat_i    ( bus_wdat_i[7:0]  ),
        .rdat_o    ( irq_rdat         ),
        .irq_src_i ( irq_src_i        ),
        .irq_o     ( irq_o            )
    );

    gpio_regs u_gpio_regs (
        .wb_clk_i  ( wb_clk_i         ),
        .reset_i   ( reset_i          ),
        .stb_i     ( gpio_stb         ),
        .we_i      ( byte_we          ),
        .reg_i     ( bus_adr_i[3:2]   ),
        .wdat_i    ( bus_wdat_i[7:0]  ),
        .rdat_o    ( gpio_rdat        ),
        .gpio_i    ( gpio_i           ),
        .gpio_o    ( gpio_o           ),
        .gpio_oe_o ( gpio_oe_o        )
    );

endmodule

/* design/access_sizer.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module access_sizer import soc_pkg::*; (
    input  logic        wb_clk_i,
    input  logic        reset_i,

    // From the request queue
    input  logic        req_valid_i,
    output logic        req_ready_o,
    input  access_req_t req_i,

    // To the response queue
    output logic        rsp_valid_o,
    input  logic        rsp_ready_i,
    output access_rsp_t rsp_o,

    // 32-bit peripheral bus
    output logic        bus_stb_o,
    output logic        bus_we_o,
    output addr_t       bus_adr_o,
    output sel_t        bus_sel_o,
    output word_t       bus_wdat_o,
    input  logic        bus_ack_i,
    input  word_t       bus_rdat_i
);

    typedef enum logic {
        s_idle,
        s_wait
    } state_t;

    state_t     state_q;
    logic       pop;
    logic       rd_pending_q;
    logic [1:0] lane_q;

    // A read needs a free response slot, a write goes anyway.
    // The slot stays free until the ack since nothing else pushes
    assign req_ready_o = (state_q == s_idle) && (req_i.we || rsp_ready_i);
    assign pop         = req_valid_i && req_ready_o;

    // ------------------------------
    // Bus cycle, issued on the pop
    // ------------------------------
    assign bus_stb_o  = pop;
    assign bus_we_o   = req_i.we;
    assign bus_adr_o  = req_i.addr;
    assign bus_sel_o  = sel_t'(1) << req_i.addr[1:0];
    assign bus_wdat_o = {`SOC_SWIDTH{req_i.data}};

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            state_q      <= s_idle;
            rd_pending_q <= 1'b0;
        end else begin
            case (state_q)
                s_idle: begin
                    if (pop) begin
                        state_q      <= s_wait;
                        rd_pending_q <= !req_i.we;
                    end
                end
                s_wait: begin
                    if (bus_ack_i) begin
                        state_q      <= s_idle;
                        rd_pending_q <= 1'b0;
                    end
                end
                default: state_q <= s_idle;
            endcase
        end
    end

    // Lane of the outstanding access
    always_ff @(posedge wb_clk_i) begin
        if (pop) begin
            lane_q <= req_i.addr[1:0];
        end
    end

    // ------------------------------
    // Read return
    // ------------------------------
    assign rsp_valid_o = (state_q == s_wait) && bus_ack_i && rd_pending_q;
    assign rsp_o.data  = bus_rdat_i[{lane_q, 3'b000} +: 8];

endmodule

/* design/soc_system.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module soc_system import soc_pkg::*; (
    input  logic                       wb_clk_i,
    input  logic                       reset_i,

    // Host request port
    input  logic                       req_valid_i,
    output logic                       req_ready_o,
    input  logic                       req_we_i,
    input  addr_t                      req_addr_i,
    input  byte_t                      req_data_i,

    // Host response port
    output logic                       rsp_valid_o,
    input  logic                       rsp_ready_i,
    output byte_t                      rsp_data_o,

    input  irq_vec_t                   irq_src_i,
    output logic [1:0]                 irq_o,

    input  logic [`SOC_GPIO_WIDTH-1:0] gpio_i,
    output logic [`SOC_GPIO_WIDTH-1:0] gpio_o,
    output logic [`SOC_GPIO_WIDTH-1:0] gpio_oe_o
);

    access_req_t req_pkt;
    access_req_t sz_req;
    logic        sz_req_valid;
    logic        sz_req_ready;
    access_rsp_t sz_rsp;
    logic        sz_rsp_valid;
    logic        sz_rsp_ready;
    access_rsp_t rsp_pkt;

    logic        bus_stb;
    logic        bus_we;
    addr_t       bus_adr;
    sel_t        bus_sel;
    word_t       bus_wdat;
    logic        bus_ack;
    word_t       bus_rdat;

    assign req_pkt.we   = req_we_i;
    assign req_pkt.addr = req_addr_i;
    assign req_pkt.data = req_data_i;
    assign rsp_data_o   = rsp_pkt.data;

    // ------------------------------
    // Host side queues
    // ------------------------------
    bus_fifo #(
        .T     ( access_req_t    ),
        .DEPTH ( `SOC_FIFO_DEPTH )
    ) u_req_fifo (
        .wb_clk_i    ( wb_clk_i     ),
        .reset_i     ( reset_i      ),
        .in_valid_i  ( req_valid_i  ),
        .in_ready_o  ( req_ready_o  ),
        .in_data_i   ( req_pkt      ),
        .out_valid_o ( sz_req_valid ),
        .out_ready_i ( sz_req_ready ),
        .out_data_o  ( sz_req       )
    );

    bus_fifo #(
        .T     ( access_rsp_t    ),
        .DEPTH ( `SOC_FIFO_DEPTH )
    ) u_rsp_fifo (
        .wb_clk_i    ( wb_clk_i     ),
        .reset_i     ( reset_i      ),
        .in_valid_i  ( sz_rsp_valid ),
        .in_ready_o  ( sz_rsp_ready ),
        .in_data_i   ( sz_rsp       ),
        .out_valid_o ( rsp_valid_o  ),
        .out_ready_i ( rsp_ready_i  ),
        .out_data_o  ( rsp_pkt      )
    );

    // ------------------------------
    // Sizer and peripheral bus
    // ------------------------------
    access_sizer u_access_sizer (
        .wb_clk_i    ( wb_clk_i     ),
        .reset_i     ( reset_i      ),
        .req_valid_i ( sz_req_valid ),
        .req_ready_o ( sz_req_ready ),
        .req_i       ( sz_req       ),
        .rsp_valid_o ( sz_rsp_valid ),
        .rsp_ready_i ( sz_rsp_ready ),
        .rsp_o       ( sz_rsp       ),
        .bus_stb_o   ( bus_stb      ),
        .bus_we_o    ( bus_we       ),
        .bus_adr_o   ( bus_adr      ),
        .bus_sel_o   ( bus_sel      ),
        .bus_wdat_o  ( bus_wdat     ),
        .bus_ack_i   ( bus_ack      ),
        .bus_rdat_i  ( bus_rdat     )
    );

    periph_bus u_periph_bus (
        .wb_clk_i   ( wb_clk_i  ),
        .reset_i    ( reset_i   ),
        .bus_stb_i  ( bus_stb   ),
        .bus_we_i   ( bus_we    ),
        .bus_adr_i  ( bus_adr   ),
        .bus_sel_i  ( bus_sel   ),
        .bus_wdat_i ( bus_wdat  ),
        .bus_ack_o  ( bus_ack   ),
        .bus_rdat_o ( bus_rdat  ),
        .irq_src_i  ( irq_src_i ),
        .irq_o      ( irq_o     ),
        .gpio_i     ( gpio_i    ),
        .gpio_o     ( gpio_o    ),
        .gpio_oe_o  ( gpio_oe_o )
    );

endmodule

/* verif/soc_properties.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module soc_properties (
    input logic                       wb_clk_i,
    input logic                       reset_i,
    input logic                       req_ready_o,
    input logic                       rsp_valid_o,
    input logic                       rsp_ready_i,
    input logic [7:0]                 rsp_data_o,
    input logic [1:0]                 irq_o,
    input logic [`SOC_GPIO_WIDTH-1:0] gpio_oe_o
);

    // Stalled response must hold
    rsp_hold: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_data_o))
        else $error("response valid or data changed while stalled");

    // Outputs quiet right after reset
    out_quiet: assert property (@(posedge wb_clk_i)
        $fell(reset_i) |-> (irq_o == 2'b00) && (gpio_oe_o == '0))
        else $error("irq_o or gpio_oe_o high after reset");

    // Request queue is empty during reset
    ready_in_reset: assert property (@(posedge wb_clk_i)
        reset_i && $past(reset_i) |-> req_ready_o)
        else $error("req_ready_o low during reset");

endmodule

bind soc_system soc_properties u_soc_properties (
    .wb_clk_i    ( wb_clk_i    ),
    .reset_i     ( reset_i     ),
    .req_ready_o ( req_ready_o ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_ready_i ( rsp_ready_i ),
    .rsp_data_o  ( rsp_data_o  ),
    .irq_o       ( irq_o       ),
    .gpio_oe_o   ( gpio_oe_o   )
);

/* verif/tb_soc_system.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module tb_soc_system;

    localparam int RESET_CYCLES  = 10;
    localparam int MAX_STEPS     = 64;
    localparam int STEP_CYCLES   = 50;
    // Worst case to empty the request path, two cycles per access
    localparam int SETTLE_CYCLES = 2 * (`SOC_FIFO_DEPTH + 1) + 2;

    logic                       wb_clk_i = 1'b0;
    logic                       reset_i;
    logic                       req_valid_i;
    logic                       req_ready_o;
    logic                       req_we_i;
    logic [15:0]                req_addr_i;
    logic [7:0]                 req_data_i;
    logic                       rsp_valid_o;
    logic                       rsp_ready_i;
    logic [7:0]                 rsp_data_o;
    logic [15:0]                irq_src_i;
    logic [1:0]                 irq_o;
    logic [`SOC_GPIO_WIDTH-1:0] gpio_i;
    logic [`SOC_GPIO_WIDTH-1:0] gpio_o;
    logic [`SOC_GPIO_WIDTH-1:0] gpio_oe_o;

    integer      seed = 32'hfcaedb98;
    int          pass_count = 0;
    int          fail_count = 0;
    int          reads_sent = 0;
    int          rsp_count = 0;
    int          step_count = 0;
    bit          steps_ready = 1'b0;

    string       step_name [MAX_STEPS];
    string       step_op   [MAX_STEPS];
    logic [15:0] step_addr [MAX_STEPS];
    logic [15:0] step_data [MAX_STEPS];
    logic [15:0] step_exp  [MAX_STEPS];

    // Reads still waiting for their response, oldest first
    string       exp_name_q [$];
    logic [15:0] exp_val_q  [$];

    soc_system i_dut (
        .wb_clk_i    ( wb_clk_i    ),
        .reset_i     ( reset_i     ),
        .req_valid_i ( req_valid_i ),
        .req_ready_o ( req_ready_o ),
        .req_we_i    ( req_we_i    ),
        .req_addr_i  ( req_addr_i  ),
        .req_data_i  ( req_data_i  ),
        .rsp_valid_o ( rsp_valid_o ),
        .rsp_ready_i ( rsp_ready_i ),
        .rsp_data_o  ( rsp_data_o  ),
        .irq_src_i   ( irq_src_i   ),
        .irq_o       ( irq_o       ),
        .gpio_i      ( gpio_i      ),
        .gpio_o      ( gpio_o      ),
        .gpio_oe_o   ( gpio_oe_o   )
    );

    always #10 wb_clk_i = ~wb_clk_i;

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            $display("FAILED %0s expected %h actual %h", name, expected, actual);
            fail_count++;
        end else begin
            $display("ok     %0s value %h", name, actual);
            pass_count++;
        end
    endtask

    task automatic load_steps();
        int          fd;
        int          code;
        string       line;
        string       name;
        string       op;
        logic [15:0] addr;
        logic [15:0] data;
        logic [15:0] expv;
        fd = $fopen("verif/soc_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file verif/soc_input.txt");
        end else begin
            while (!$feof(fd) && step_count < MAX_STEPS) begin
                code = $fgets(line, fd);
                if (code > 0 && line.substr(0, 0) != "#") begin
                    code = $sscanf(line, "%s %s %h %h %h", name, op, addr, data, expv);
                    if (code == 5) begin
                        step_name[step_count] = name;
                        step_op[step_count]   = op;
                        step_addr[step_count] = addr;
                        step_data[step_count] = data;
                        step_exp[step_count]  = expv;
                        step_count++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Valid/ready transfer on the host request port
    task automatic send_request(input logic we, input logic [15:0] addr, input logic [7:0] data);
        req_valid_i = 1'b1;
        req_we_i    = we;
        req_addr_i  = addr;
        req_data_i  = data;
        @(posedge wb_clk_i);
        while (!req_ready_o) begin
            @(posedge wb_clk_i);
        end
        #1;
        req_valid_i = 1'b0;
    endtask

    // All reads answered and queued writes landed
    task automatic drain();
        while (exp_val_q.size() != 0) begin
            @(posedge wb_clk_i);
        end
        repeat (SETTLE_CYCLES) @(posedge wb_clk_i);
        #1;
    endtask

    // ------------------------------
    // Response monitor and stalls
    // ------------------------------
    always @(posedge wb_clk_i) begin
        if (!reset_i && rsp_valid_o && rsp_ready_i) begin
            rsp_count++;
            if (exp_val_q.size() == 0) begin
                $display("Response %h arrived with no read outstanding", rsp_data_o);
                fail_count++;
            end else begin
                check_value(exp_name_q.pop_front(), exp_val_q.pop_front(), {8'h00, rsp_data_o});
            end
        end
    end

    initial begin
        rsp_ready_i = 1'b0;
        forever begin
            @(posedge wb_clk_i);
            #1;
            rsp_ready_i = (($random(seed) & 3) != 0);
        end
    end

    initial begin
        wait (steps_ready);
        repeat (step_count * STEP_CYCLES + RESET_CYCLES) @(posedge wb_clk_i);
        $display("Timeout: the run did not finish within %0d cycles",
                 step_count * STEP_CYCLES + RESET_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        reset_i     = 1'b1;
        req_valid_i = 1'b0;
        req_we_i    = 1'b0;
        req_addr_i  = '0;
        req_data_i  = '0;
        irq_src_i   = '0;
        gpio_i      = '0;
        load_steps();
        if (step_count == 0) begin
            $display("No test steps were loaded");
            $display("Simulation FAILED");
            $finish;
        end else begin
            steps_ready = 1'b1;
            repeat (RESET_CYCLES) @(posedge wb_clk_i);
            #1;
            reset_i = 1'b0;

            for (int i = 0; i < step_count; i++) begin
                if (step_op[i] == "W") begin
                    send_request(1'b1, step_addr[i], step_data[i][7:0]);
                    $display("done   %0s", step_name[i]);
                end else if (step_op[i] == "R") begin
                    send_request(1'b0, step_addr[i], 8'h00);
                    exp_name_q.push_back(step_name[i]);
                    exp_val_q.push_back(step_exp[i]);
                    reads_sent++;
                end else if (step_op[i] == "SRC") begin
                    drain();
                    irq_src_i = step_data[i];
                    @(posedge wb_clk_i);
                    #1;
                    $display("done   %0s", step_name[i]);
                end else if (step_op[i] == "PIN") begin
                    drain();
                    gpio_i = step_data[i][7:0];
                    // Covers the two-stage input synchronizer
                    repeat (3) @(posedge wb_clk_i);
                    #1;
                    check_value(step_name[i], step_exp[i], {gpio_oe_o, gpio_o});
                end else if (step_op[i] == "CHKIRQ") begin
                    drain();
                    check_value(step_name[i], step_exp[i], {14'h0, irq_o});
                end else begin
                    $display("Step %0s has an unknown operation %0s", step_name[i], step_op[i]);
                    fail_count++;
                end
            end

            drain();
            check_value("response_count", 16'(reads_sent), 16'(rsp_count));
            $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("Simulation PASSED");
            end else begin
                $display("Simulation FAILED");
            end
            $finish;
        end
    end

endmodule

/* verilog.f */
+incdir+include
design/soc_pkg.sv
design/bus_fifo.sv
design/data_ram.sv
design/irq_ctrl.sv
design/gpio_regs.sv
design/periph_bus.sv
design/access_sizer.sv
design/soc_system.sv
verif/soc_properties.sv
verif/tb_soc_system.sv

/* Makefile */
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_soc_system
FILELIST ?= verilog.f
OBJ_DIR  ?= obj_dir
PASS_MSG  = Simulation PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verif/soc_input.txt */
# name op addr data expected, last three in hex
# ops: W write, R read, SRC irq sources, PIN gpio_i with {oe,out} check, CHKIRQ irq_o
ram_w0       W      0010 11   0
ram_w1       W      0011 22   0
ram_w2       W      0012 33   0
ram_w3       W      0013 44   0
ram_w4       W      0020 a1   0
ram_w5       W      0021 b2   0
ram_w6       W      0022 c3   0
ram_w7       W      0023 d4   0
ram_lane2    W      0012 5a   0
ram_r0       R      0010 0    11
ram_r1       R      0011 0    22
ram_r2       R      0012 0    5a
ram_r3       R      0013 0    44
ram_r4       R      0020 0    a1
ram_r5       R      0021 0    b2
ram_r6       R      0022 0    c3
ram_r7       R      0023 0    d4
unmap_w      W      4000 77   0
unmap_r      R      4000 0    00
gpio_out     W      9004 a5   0
gpio_dir     W      9008 0f   0
gpio_pins    PIN    0000 3c   0fa5
gpio_in_r    R      9000 0    3c
irq_mask     W      8008 08   0
irq_src3_on  SRC    0000 0008 0
irq_src3_off SRC    0000 0000 0
irq_lo_on    CHKIRQ 0000 0    0001
irq_pend_lo  R      8000 0    08
irq_src8_on  SRC    0000 0100 0
irq_src8_off SRC    0000 0000 0
irq_pend_hi  R      8004 0    01
irq_hi_mask  CHKIRQ 0000 0    0001
irq_clr_lo   W      8000 08   0
irq_lo_off   CHKIRQ 0000 0    0000
irq_lo_rd    R      8000 0    00
